// File: design/pixelPkg.sv
//----------------------------------------
// pixel mapper shared types, screen
// constants and the palette table
//----------------------------------------
package pixelPkg;

    //----------------------------------------
    // widths that carry a meaning
    //----------------------------------------
    typedef logic [9:0]  coordT;
    // 12 bits so the tile region above the player sheet is reachable
    typedef logic [11:0] spriteAddrT;
    typedef logic [4:0]  paletteIdxT;
    typedef logic [23:0] rgbT;
    typedef logic [1:0]  frameT;

    typedef enum logic [1:0] {
        LayerBackground,
        LayerBlock,
        LayerPlayer
    } layerT;

    // one pixel request from the scan side
    typedef struct packed {
        coordT drawX;
        coordT drawY;
        logic  isPlayer;
        logic  isBlock;
        logic  facingRight;
        frameT frame;
    } pixelReqT;

    // resolved job between producer and consumer
    typedef struct packed {
        layerT      layer;
        spriteAddrT spriteAddr;
        coordT      drawX;
    } pixelJobT;

    // host write into the sprite memory
    typedef struct packed {
        logic       en;
        spriteAddrT addr;
        paletteIdxT data;
    } spriteWrT;

    //----------------------------------------
    // sprite sheet geometry
    //----------------------------------------
    localparam int SpriteW    = 25;
    localparam int SpriteH    = 21;
    localparam int FrameCount = 4;
    localparam int SheetW     = FrameCount * SpriteW;
    localparam int TileSize   = 20;
    // tile pixels sit right after the player sheet
    localparam int TileBase   = SheetW * SpriteH;
    localparam int RamWords   = TileBase + TileSize * TileSize;

    // gradient background
    localparam int        ScreenHalf = 320;
    localparam logic [7:0] GradLow   = 8'h80;
    localparam logic [7:0] GradHigh  = 8'hFF;

    //----------------------------------------
    // palette
    //----------------------------------------
    localparam paletteIdxT TransparentIdx = 5'd0;
    localparam int         PaletteCount   = 30;
    localparam rgbT        KeyRgb         = 24'hF400FF;

    localparam rgbT PaletteRgb [PaletteCount] = '{
        24'hF400FF, 24'hFFFFFE, 24'hC9C9C9, 24'h030303, 24'h1E1E1E,
        24'h474747, 24'h3F0606, 24'h880606, 24'hAB0000, 24'hA40000,
        24'h5A2712, 24'hDF4426, 24'hFF0000, 24'hFFC78F, 24'hEFE300,
        24'h154269, 24'h323E92, 24'hED1C24, 24'h342505, 24'h47450F,
        24'h126401, 24'h064100, 24'h080000, 24'h1E0B05, 24'h893A1A,
        24'h873B19, 24'hB35A32, 24'hF30000, 24'h640000, 24'hF35B5B
    };

endpackage

// File: design/layerAddrGen.sv
//----------------------------------------
// layerAddrGen: picks the pixel's layer and
// its sprite memory address, spends credits
//----------------------------------------
`timescale 1ns/1ps

module layerAddrGen #(
    parameter int Depth = 4
) (
    input  logic               Clk,
    input  logic               rst,
    input  pixelPkg::pixelReqT req,
    input  logic               reqValid,
    input  pixelPkg::coordT    playerX,
    input  pixelPkg::coordT    playerY,
    input  logic               creditReturn,
    output logic               reqReady,
    output pixelPkg::pixelJobT job,
    output logic               jobValid
);
    import pixelPkg::*;

    localparam int CntW = $clog2(Depth + 1);
    // sprite anchor inside one frame
    localparam int PivotCol = 12;
    localparam int PivotRow = 9;

    logic [CntW-1:0] credits;
    logic            haveCredit;
    logic            live;
    logic            outValid;
    logic            accept;
    pixelJobT        outJob;
    pixelJobT        nextJob;
    spriteAddrT      dx;
    spriteAddrT      dy;
    spriteAddrT      col;
    spriteAddrT      row;

    //----------------------------------------
    // layer select and address math
    //----------------------------------------
    always_comb
    begin
        // offsets from the player anchor, modulo the address width
        dx  = spriteAddrT'(req.drawX) - spriteAddrT'(playerX);
        dy  = spriteAddrT'(req.drawY) - spriteAddrT'(playerY);
        // mirror around the pivot column when facing left
        col = req.facingRight ? spriteAddrT'(PivotCol) + dx : spriteAddrT'(PivotCol) - dx;
        row = spriteAddrT'(PivotRow) + dy;

        nextJob.drawX = req.drawX;
        if (req.isPlayer)
        begin
            nextJob.layer      = LayerPlayer;
            nextJob.spriteAddr = spriteAddrT'(int'(row) * SheetW
                                 + int'(req.frame) * SpriteW + int'(col));
        end
        else if (req.isBlock)
        begin
            // tile repeats every TileSize pixels both ways
            nextJob.layer      = LayerBlock;
            nextJob.spriteAddr = spriteAddrT'(TileBase
                                 + (int'(req.drawY) % TileSize) * TileSize
                                 + int'(req.drawX) % TileSize);
        end
        else
        begin
            nextJob.layer      = LayerBackground;
            nextJob.spriteAddr = '0;
        end
    end

    //----------------------------------------
    // handshake and credits
    //----------------------------------------
    assign haveCredit = (credits != '0);
    assign jobValid   = outValid && haveCredit;
    assign reqReady   = live && (!outValid || haveCredit);
    assign accept     = reqValid && reqReady;
    assign job        = outJob;

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            live     <= 1'b0;
            outValid <= 1'b0;
            credits  <= CntW'(Depth);
        end
        else
        begin
            live    <= 1'b1;
            credits <= credits - CntW'(jobValid) + CntW'(creditReturn);
            if (accept)
                outValid <= 1'b1;
            else if (jobValid)
                outValid <= 1'b0;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (accept)
            outJob <= nextJob;
    end

    // credits come back from the buffer, never more than were handed out
    creditBound: assert property (@(posedge Clk) disable iff (rst)
        credits <= CntW'(Depth))
        else $error("credit counter above Depth");

endmodule

// File: design/creditFifo.sv
//----------------------------------------
// creditFifo: circular job buffer, one
// credit back to the producer per pop
//----------------------------------------
`timescale 1ns/1ps

module creditFifo #(
    parameter int Depth = 4
) (
    input  logic               Clk,
    input  logic               rst,
    input  pixelPkg::pixelJobT job,
    input  logic               jobValid,
    input  logic               pop,
    output pixelPkg::pixelJobT head,
    output logic               headValid,
    output logic               creditReturn
);
    import pixelPkg::*;

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    pixelJobT        slots [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;

    assign head         = slots[rdPtr];
    assign headValid    = (count != '0);
    // credit goes back in the pop cycle itself
    assign creditReturn = pop;

    // storage
    always_ff @(posedge Clk)
    begin
        if (jobValid)
            slots[wrPtr] <= job;
    end

    //----------------------------------------
    // pointers and occupancy
    //----------------------------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (jobValid)
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            count <= count + CntW'(jobValid) - CntW'(pop);
        end
    end

    // the producer's credit count should keep pushes out of a full buffer
    noOverflow: assert property (@(posedge Clk) disable iff (rst)
        jobValid |-> (count < CntW'(Depth)))
        else $error("push into full job buffer");

    noUnderflow: assert property (@(posedge Clk) disable iff (rst)
        pop |-> headValid)
        else $error("pop from empty job buffer");

endmodule

// File: design/spriteRam.sv
//----------------------------------------
// spriteRam: palette index memory, host
// write port and registered read port
//----------------------------------------
`timescale 1ns/1ps

module spriteRam (
    input  logic                 Clk,
    input  pixelPkg::spriteWrT   spriteWr,
    input  pixelPkg::spriteAddrT rdAddr,
    output pixelPkg::paletteIdxT rdData
);
    import pixelPkg::*;

    // player sheet followed by one block tile
    paletteIdxT mem [RamWords];

    // host load
    always_ff @(posedge Clk)
    begin
        if (spriteWr.en)
            mem[spriteWr.addr] <= spriteWr.data;
    end

    // data shows one cycle after the address
    always_ff @(posedge Clk)
    begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: design/pixelCompositor.sv
//----------------------------------------
// consumer with sprite read, palette
// lookup and gradient fallback
//----------------------------------------
`timescale 1ns/1ps

module pixelCompositor (
    input  logic                 Clk,
    input  logic                 rst,
    input  pixelPkg::pixelJobT   head,
    input  logic                 headValid,
    input  pixelPkg::paletteIdxT rdData,
    input  logic                 pixReady,
    output logic                 pop,
    output pixelPkg::spriteAddrT rdAddr,
    output pixelPkg::rgbT        pixOut,
    output logic                 pixValid
);
    import pixelPkg::*;

    logic       advance;
    logic       s1Valid;
    layerT      s1Layer;
    coordT      s1DrawX;
    spriteAddrT s1Addr;
    rgbT        color;

    // gray level of the horizontal gradient
    // brightest at the center column
    function automatic logic [7:0] grayLevel(input coordT x);
        int span;
        int level;
        span = int'(GradHigh) - int'(GradLow);
        if (int'(x) < ScreenHalf)
            level = int'(GradLow) + int'(x) * span / ScreenHalf;
        else
            level = int'(GradHigh) - (int'(x) - ScreenHalf) * span / ScreenHalf;
        return 8'(level);
    endfunction

    //----------------------------------------
    // flow control
    //----------------------------------------
    // output register free or draining this cycle
    assign advance = !pixValid || pixReady;
    assign pop     = headValid && advance;
    // on a stall the held address keeps rdData steady
    assign rdAddr  = pop ? head.spriteAddr : s1Addr;

    //----------------------------------------
    // color select
    //----------------------------------------
    always_comb
    begin
        if (s1Layer == LayerBackground || rdData == TransparentIdx)
            color = {3{grayLevel(s1DrawX)}};
        else if (int'(rdData) < PaletteCount)
            color = PaletteRgb[rdData];
        else
            color = KeyRgb;
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            s1Valid  <= 1'b0;
            pixValid <= 1'b0;
        end
        else if (advance)
        begin
            s1Valid  <= pop;
            pixValid <= s1Valid;
        end
    end

    // stage registers
    always_ff @(posedge Clk)
    begin
        if (pop)
        begin
            s1Layer <= head.layer;
            s1DrawX <= head.drawX;
            s1Addr  <= head.spriteAddr;
        end
        if (advance && s1Valid)
            pixOut <= color;
    end

    // pixel held until the sink takes it
    holdOnStall: assert property (@(posedge Clk) disable iff (rst)
        (pixValid && !pixReady) |=> (pixValid && $stable(pixOut)))
        else $error("pixOut changed under back-pressure");

endmodule

// File: design/colorMapperTop.sv
//----------------------------------------
// colorMapperTop: producer, job buffer,
// sprite memory and compositor
//----------------------------------------
`timescale 1ns/1ps

module colorMapperTop #(
    parameter int Depth = 4
) (
    input  logic               Clk,
    input  logic               rst,
    input  pixelPkg::pixelReqT req,
    input  logic               reqValid,
    input  pixelPkg::coordT    playerX,
    input  pixelPkg::coordT    playerY,
    input  pixelPkg::spriteWrT spriteWr,
    input  logic               pixReady,
    output logic               reqReady,
    output pixelPkg::rgbT      pixOut,
    output logic               pixValid
);
    import pixelPkg::*;

    pixelJobT   job;
    logic       jobValid;
    logic       creditReturn;
    pixelJobT   head;
    logic       headValid;
    logic       pop;
    spriteAddrT rdAddr;
    paletteIdxT rdData;

    // request side
    layerAddrGen #(
        .Depth(Depth)
    ) producer (
        .Clk          (Clk),
        .rst          (rst),
        .req          (req),
        .reqValid     (reqValid),
        .playerX      (playerX),
        .playerY      (playerY),
        .creditReturn (creditReturn),
        .reqReady     (reqReady),
        .job          (job),
        .jobValid     (jobValid)
    );

    creditFifo #(
        .Depth(Depth)
    ) jobBuffer (
        .Clk          (Clk),
        .rst          (rst),
        .job          (job),
        .jobValid     (jobValid),
        .pop          (pop),
        .head         (head),
        .headValid    (headValid),
        .creditReturn (creditReturn)
    );

    spriteRam sprites (
        .Clk      (Clk),
        .spriteWr (spriteWr),
        .rdAddr   (rdAddr),
        .rdData   (rdData)
    );

    // pixel side
    pixelCompositor compositor (
        .Clk       (Clk),
        .rst       (rst),
        .head      (head),
        .headValid (headValid),
        .rdData    (rdData),
        .pixReady  (pixReady),
        .pop       (pop),
        .rdAddr    (rdAddr),
        .pixOut    (pixOut),
        .pixValid  (pixValid)
    );

endmodule

// File: tests/colorMapperTb.sv
//----------------------------------------
// trace driven color mapper testbench
// with random and held pixReady
//----------------------------------------
`timescale 1ns/1ps

module colorMapperTb;
    import pixelPkg::*;

    localparam int Depth       = 4;
    // cycles of steady reqReady low before the stall is judged
    localparam int StallWindow = 8;

    logic       Clk;
    logic       rst;
    pixelReqT   req;
    logic       reqValid;
    coordT      playerX;
    coordT      playerY;
    spriteWrT   spriteWr;
    logic       pixReady;
    logic       reqReady;
    rgbT        pixOut;
    logic       pixValid;

    // trace contents
    pixelReqT   reqList [$];
    rgbT        expList [$];
    string      nameList [$];
    spriteAddrT wrAddr [$];
    paletteIdxT wrData [$];
    coordT      traceX;
    coordT      traceY;

    // pixels accepted but not yet seen at the output
    rgbT        pendRgb [$];
    string      pendName [$];

    int          totalReqs;
    int          received;
    int          cycleCount;
    int          cycleLimit;
    bit          holdLow;

    colorMapperTop #(
        .Depth(Depth)
    ) DUT (
        .Clk      (Clk),
        .rst      (rst),
        .req      (req),
        .reqValid (reqValid),
        .playerX  (playerX),
        .playerY  (playerY),
        .spriteWr (spriteWr),
        .pixReady (pixReady),
        .reqReady (reqReady),
        .pixOut   (pixOut),
        .pixValid (pixValid)
    );

    initial
    begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    //----------------------------------------
    // helpers
    //----------------------------------------
    task automatic expectEqual(input string testName, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected %h, actual %h", testName, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic readTrace();
        int       fd;
        int       n;
        int       a;
        int       b;
        int       c;
        int       d;
        int       e;
        int       f;
        string    line;
        string    tag;
        string    name;
        rgbT      rgb;
        pixelReqT r;
        fd = $fopen("tests/pixelTrace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file tests/pixelTrace.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "trace file missing");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                // skip comments and blank lines
                if (n > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%s", tag);
                    if (tag == "H")
                    begin
                        n = $sscanf(line, "%s %d %d", tag, a, b);
                        traceX = coordT'(a);
                        traceY = coordT'(b);
                    end
                    else if (tag == "W")
                    begin
                        n = $sscanf(line, "%s %d %d", tag, a, b);
                        wrAddr.push_back(spriteAddrT'(a));
                        wrData.push_back(paletteIdxT'(b));
                    end
                    else if (tag == "P")
                    begin
                        n = $sscanf(line, "%s %s %d %d %d %d %d %d %h",
                                    tag, name, a, b, c, d, e, f, rgb);
                        r.drawX       = coordT'(a);
                        r.drawY       = coordT'(b);
                        r.isPlayer    = (c != 0);
                        r.isBlock     = (d != 0);
                        r.facingRight = (e != 0);
                        r.frame       = frameT'(f);
                        reqList.push_back(r);
                        expList.push_back(rgb);
                        nameList.push_back(name);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic loadSprites();
        for (int i = 0; i < wrAddr.size(); i++)
        begin
            spriteWr.en   = 1'b1;
            spriteWr.addr = wrAddr[i];
            spriteWr.data = wrData[i];
            @(posedge Clk);
            #1;
        end
        spriteWr = '0;
    endtask

    // two passes over the trace
    // pixReady is held low at the start of the first
    task automatic driveRequests();
        int k;
        int idx;
        int accepted;
        int idle;
        k        = 0;
        accepted = 0;
        idle     = 0;
        while (k < totalReqs)
        begin
            idx      = k % reqList.size();
            req      = reqList[idx];
            reqValid = 1'b1;
            @(negedge Clk);
            if (reqReady)
            begin
                pendRgb.push_back(expList[idx]);
                pendName.push_back(nameList[idx]);
                k++;
                accepted++;
                idle = 0;
            end
            else if (holdLow)
            begin
                idle++;
                if (idle == StallWindow)
                begin
                    expectEqual("backpressure_limit", 32'(1), 32'(accepted <= Depth + 3));
                    holdLow = 1'b0;
                end
            end
            @(posedge Clk);
            #1;
        end
        reqValid = 1'b0;
        // reqReady has to drop before the whole trace is in
        expectEqual("backpressure_stall", 32'(0), 32'(holdLow));
    endtask

    task automatic takePixel();
        string name;
        rgbT   expected;
        if (pendRgb.size() == 0)
        begin
            $display("a pixel came out with no request outstanding");
            $display("TEST RESULT: FAIL");
            $fatal(1, "unexpected pixel");
        end
        else
        begin
            name     = pendName.pop_front();
            expected = pendRgb.pop_front();
            expectEqual(name, 32'(expected), 32'(pixOut));
            received++;
        end
    endtask

    //----------------------------------------
    // processes
    //----------------------------------------
    initial
    begin
        forever
        begin
            @(posedge Clk);
            #1;
            if (holdLow)
                pixReady = 1'b0;
            else
                pixReady = ($urandom % 4) != 0;
        end
    end

    // outputs sampled mid-cycle
    initial
    begin
        forever
        begin
            @(negedge Clk);
            if (!rst && pixValid && pixReady)
                takePixel();
        end
    end

    initial
    begin
        cycleCount = 0;
        wait (cycleLimit != 0);
        while (cycleCount < cycleLimit)
        begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, %0d of %0d pixels received",
                 cycleCount, received, totalReqs);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation timed out");
    end

    initial
    begin
        rst      = 1'b1;
        req      = '0;
        reqValid = 1'b0;
        playerX  = '0;
        playerY  = '0;
        spriteWr = '0;
        pixReady = 1'b0;
        holdLow  = 1'b1;
        received = 0;
        void'($urandom(32'hc3ec));

        readTrace();
        totalReqs  = 2 * reqList.size();
        cycleLimit = 200 + 20 * totalReqs;

        repeat (10) @(posedge Clk);
        #1;
        rst     = 1'b0;
        playerX = traceX;
        playerY = traceY;

        // memory is loaded before any request is in flight
        loadSprites();
        driveRequests();

        while (received < totalReqs)
            @(posedge Clk);
        // idle cycles let any extra pixel show up
        repeat (10) @(posedge Clk);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: tests/pixelTrace.txt
# H playerX playerY                      (decimal)
# W address paletteIndex                 (decimal)
# P name drawX drawY isPlayer isBlock facingRight frame expectedRgb (rgb in hex)
H 200 100
W 1115 12
W 1116 5
W 1109 16
W 1110 8
W 1190 20
W 1191 9
W 1447 0
W 2245 14
W 2246 27
W 472 3
W 471 1
W 0 2
P bg_x0 0 10 0 0 0 0 808080
P bg_x100 100 10 0 0 0 0 A7A7A7
P bg_x319 319 40 0 0 0 0 FEFEFE
P bg_x320 320 40 0 0 0 0 FFFFFF
P bg_x639 639 479 0 0 0 0 818181
P player_right_f0 203 102 1 0 1 0 FF0000
P player_left_f0 203 102 1 0 0 0 323E92
P player_right_f3 203 102 1 0 1 3 126401
P player_transparent 210 105 1 1 1 1 D3D3D3
P block_5_7 5 7 0 1 0 0 EFE300
P block_45_67 45 67 0 1 0 0 EFE300
P player_left_f2 190 95 1 0 0 2 030303

// File: files.f
design/pixelPkg.sv
design/layerAddrGen.sv
design/creditFifo.sv
design/spriteRam.sv
design/pixelCompositor.sv
design/colorMapperTop.sv
tests/colorMapperTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = colorMapperTb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail
sim:
	$(TOOL) --binary $(FLAGS) -j 0 --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
